/* capture.f */
capture_pkg.sv
capture_ctrl_if.sv
capture_control.sv
fake_antenna_lfsr.sv
sample_frontend.sv
raw_store.sv
capture_top.sv
tb_clock_gen.sv
capture_sva.sv
capture_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the capture testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module capture_tb -f capture.f

# the run itself may stop with a fatal, the log decides
./obj_dir/Vcapture_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
   echo "simulation result: PASS"
else
   echo "simulation result: FAIL"
   exit 1
fi

/* capture_tb.sv */
module capture_tb import capture_pkg::*;
();

   localparam logic [31:0] RAND_SEED = 32'h78a4;
   localparam int RST_CYCLES = 4;
   localparam int P1_LEN = 60;                   // ce toggles
   localparam int P2_LEN = 60;                   // real antenna words
   localparam int P3_LEN = 80;                   // fake data
   localparam int P4_LEN = 120;                  // nominal fill with ce gaps
   localparam int P4_TAIL = 12;                  // samples offered after full
   localparam int P5_LEN = 2 * STORE_DEPTH + 34; // two read sweeps plus session
   localparam int CYCLE_LIMIT = 4 * (RST_CYCLES + P1_LEN + P2_LEN + P3_LEN
                                     + P4_LEN + P4_TAIL + P5_LEN);
   localparam logic [STORE_AW:0] FULL_CNT = (STORE_AW+1)'(STORE_DEPTH);

   typedef enum logic [1:0] {M_IDLE, M_FILL, M_FULL} model_state_e;

   logic                clk_e;
   logic                arst_n;
   logic                ce_a;
   logic                debug_a;
   logic                store_a;
   logic [NUM_ANT-1:0]  antenna;
   logic [STORE_AW-1:0] rd_addr;
   logic [NUM_ANT-1:0]  sample;
   logic                sample_valid;
   logic [NUM_ANT-1:0]  rd_data;
   logic [STORE_AW:0]   store_count;
   logic                store_full;

   //--------------------
   // reference model state
   //--------------------
   logic [2:0]          ce_pipe;     // re-register plus two sync stages
   logic [2:0]          debug_pipe;
   logic [2:0]          store_pipe;
   int                  rel_cnt;     // edges since arst_n rose
   logic [LFSR_W-1:0]   m_lfsr;
   logic [NUM_ANT-1:0]  m_sample;
   logic                m_valid;
   model_state_e        m_state;
   logic [STORE_AW:0]   m_count;
   logic [NUM_ANT-1:0]  m_mem [STORE_DEPTH];
   logic                m_known [STORE_DEPTH]; // entry written at least once
   logic [NUM_ANT-1:0]  m_rd_data;
   logic                m_rd_known;

   logic                rst_hold;    // keep arst_n low
   logic                check_rd;    // read port under test
   logic                ce_lvl;
   int                  cycle_cnt = 0;

   tb_clock_gen clk_src
   (
      .clk_o (clk_e)
   );

   capture_top dut0
   (
      .clk_e_i        (clk_e),
      .arst_n_i       (arst_n),
      .ce_a_i         (ce_a),
      .debug_a_i      (debug_a),
      .store_a_i      (store_a),
      .antenna_i      (antenna),
      .rd_addr_i      (rd_addr),
      .sample_o       (sample),
      .sample_valid_o (sample_valid),
      .rd_data_o      (rd_data),
      .store_count_o  (store_count),
      .store_full_o   (store_full)
   );

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         fail_run($sformatf("Error at time %0t: %s is %0h, expected %0h",
                            $time, name, got, exp));
      end
   endtask

   function automatic logic chance(input int pct);
      return ($urandom_range(99, 0) < pct); // true pct percent of the time
   endfunction

   function automatic logic [NUM_ANT-1:0] rand_word();
      return NUM_ANT'($urandom);
   endfunction

   // one rising edge of the capture core
   task automatic advance_model();
      logic               c_rst;
      logic               c_ce;
      logic               c_dbg;
      logic               c_st;
      logic [NUM_ANT-1:0] fake;
      logic               fb;
      m_rd_data  = m_mem[rd_addr]; // read sees buffer before this edge's write
      m_rd_known = m_known[rd_addr];
      if (!arst_n)
      begin
         ce_pipe    = '0;
         debug_pipe = '0;
         store_pipe = '0;
         rel_cnt    = 0;
         m_lfsr     = FAKE_SEED;
         m_sample   = '0;
         m_valid    = 1'b0;
         m_state    = M_IDLE;
         m_count    = '0;
      end
      else
      begin
         c_rst = (rel_cnt < 2);  // internal reset still on
         c_ce  = ce_pipe[2];
         c_dbg = debug_pipe[2];
         c_st  = store_pipe[2];
         fake  = m_lfsr[NUM_ANT-1:0];
         // store first as it takes the word registered last edge
         if (c_rst)
         begin
            m_state = M_IDLE;
            m_count = '0;
         end
         else
         begin
            case (m_state)
               M_IDLE:
               begin
                  if (c_st)
                  begin
                     m_state = M_FILL;
                     m_count = '0;
                  end
               end
               M_FILL:
               begin
                  if (!c_st)
                  begin
                     m_state = M_IDLE;
                  end
                  else if (m_valid)
                  begin
                     m_mem[m_count[STORE_AW-1:0]]   = m_sample;
                     m_known[m_count[STORE_AW-1:0]] = 1'b1;
                     m_count = m_count + 1'b1;
                     if (m_count == FULL_CNT)
                     begin
                        m_state = M_FULL;
                     end
                  end
               end
               default:
               begin
                  if (!c_st)
                  begin
                     m_state = M_IDLE; // samples dropped until store falls
                  end
               end
            endcase
         end
         // frontend register
         if (c_rst)
         begin
            m_sample = '0;
            m_valid  = 1'b0;
         end
         else
         begin
            m_valid = c_ce;
            if (c_ce)
            begin
               m_sample = c_dbg ? fake : antenna;
            end
         end
         // lfsr with taps 16 14 13 11
         if (c_rst)
         begin
            m_lfsr = FAKE_SEED;
         end
         else if (c_ce && c_dbg)
         begin
            fb     = m_lfsr[15] ^ m_lfsr[13] ^ m_lfsr[12] ^ m_lfsr[10];
            m_lfsr = {m_lfsr[LFSR_W-2:0], fb};
         end
         ce_pipe    = {ce_pipe[1:0], ce_a};
         debug_pipe = {debug_pipe[1:0], debug_a};
         store_pipe = {store_pipe[1:0], store_a};
         if (rel_cnt < 2)
         begin
            rel_cnt = rel_cnt + 1;
         end
      end
   endtask

   task automatic compare_outputs();
      check_value("sample_valid_o", sample_valid, m_valid);
      check_value("sample_o", sample, m_sample);
      check_value("store_count_o", store_count, m_count);
      check_value("store_full_o", store_full, m_state == M_FULL);
      if (check_rd && m_rd_known)
      begin
         check_value("rd_data_o", rd_data, m_rd_data);
      end
   endtask

   // check last edge's outputs then drive the next inputs
   task automatic drive_cycle(input logic ce, input logic dbg, input logic st,
                              input logic [NUM_ANT-1:0] ant,
                              input logic [STORE_AW-1:0] addr);
      @(negedge clk_e);
      compare_outputs();
      arst_n  = !rst_hold;
      ce_a    = ce;
      debug_a = dbg;
      store_a = st;
      antenna = ant;
      rd_addr = addr;
      advance_model();
   endtask

   // run limit
   always @(posedge clk_e)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT)
      begin
         fail_run($sformatf("Run did not finish within %0d cycles", CYCLE_LIMIT));
      end
   end

   initial
   begin
      void'($urandom(RAND_SEED));
      rst_hold = 1'b1;
      check_rd = 1'b0;
      arst_n   = 1'b0;
      ce_a     = 1'b0;
      debug_a  = 1'b0;
      store_a  = 1'b0;
      antenna  = '0;
      rd_addr  = '0;
      for (int i = 0; i < STORE_DEPTH; i++)
      begin
         m_known[i] = 1'b0;
      end
      advance_model(); // model starts in reset
      @(posedge clk_e); // first edge is in reset

      //--------------------
      // reset and ce sync
      //--------------------
      repeat (RST_CYCLES - 1) drive_cycle(1'b0, 1'b0, 1'b0, '0, '0); // first from t=0
      rst_hold = 1'b0;
      ce_lvl   = 1'b0;
      repeat (P1_LEN)
      begin
         if (chance(30))
         begin
            ce_lvl = !ce_lvl; // random level toggles
         end
         drive_cycle(ce_lvl, 1'b0, 1'b0, rand_word(), '0);
      end

      // real capture with debug off
      repeat (P2_LEN) drive_cycle(1'b1, 1'b0, 1'b0, rand_word(), '0);

      // fake data with the lfsr frozen in ce gaps
      repeat (P3_LEN) drive_cycle(chance(80), 1'b1, 1'b0, rand_word(), '0);

      //--------------------
      // store fill and full
      //--------------------
      while (store_full !== 1'b1)
      begin
         drive_cycle(chance(75), 1'b0, 1'b1, rand_word(), '0);
      end
      check_value("store_count_o", store_count, FULL_CNT);
      repeat (P4_TAIL) drive_cycle(1'b1, 1'b0, 1'b1, rand_word(), '0); // count stays

      //--------------------
      // read-back
      //--------------------
      repeat (4) drive_cycle(1'b1, 1'b0, 1'b0, rand_word(), '0); // store off synced
      check_rd = 1'b1;
      for (int a = 0; a < STORE_DEPTH; a++)
      begin
         drive_cycle(1'b1, 1'b0, 1'b0, rand_word(), STORE_AW'(a));
      end
      drive_cycle(1'b1, 1'b0, 1'b0, rand_word(), '0); // last address compared
      // second session rewrites from 0
      repeat (24) drive_cycle(1'b1, 1'b0, 1'b1, rand_word(), STORE_AW'($urandom));
      repeat (4) drive_cycle(1'b1, 1'b0, 1'b0, rand_word(), '0);
      for (int a = 0; a < STORE_DEPTH; a++)
      begin
         drive_cycle(1'b0, 1'b0, 1'b0, rand_word(), STORE_AW'(a));
      end
      drive_cycle(1'b0, 1'b0, 1'b0, rand_word(), '0);

      $display("Testbench passed");
      $finish;
   end

endmodule

/* capture_sva.sv */
// checks on the capture outputs, attached to capture_top
module capture_sva import capture_pkg::*;
(
   input logic                clk_e_i,        // external signal clock
   input logic                arst_n_i,       // async reset, active low
   input logic                sample_valid_i, // frontend strobe
   input logic [STORE_AW:0]   store_count_i,  // words stored
   input logic                store_full_i    // buffer full flag
);

   localparam logic [STORE_AW:0] DEPTH_CNT = (STORE_AW+1)'(STORE_DEPTH);

   // reset held over two edges, no strobe may come out
   valid_low_in_reset: assert property (@(posedge clk_e_i)
      (!arst_n_i && $past(!arst_n_i)) |-> !sample_valid_i)
      else $error("sample_valid_o high during reset");

   count_in_range: assert property (@(posedge clk_e_i) disable iff (!arst_n_i)
      store_count_i <= DEPTH_CNT)
      else $error("store_count_o above buffer depth");

   // full flag only with every entry written
   full_means_depth: assert property (@(posedge clk_e_i) disable iff (!arst_n_i)
      store_full_i |-> (store_count_i == DEPTH_CNT))
      else $error("store_full_o high with count below depth");

endmodule

bind capture_top capture_sva u_sva
(
   .clk_e_i        (clk_e_i),
   .arst_n_i       (arst_n_i),
   .sample_valid_i (sample_valid_o),
   .store_count_i  (store_count_o),
   .store_full_i   (store_full_o)
);

/* tb_clock_gen.sv */
// free running clock for the capture testbench
module tb_clock_gen
(
   output logic clk_o // period 4
);

   initial
   begin
      clk_o = 1'b0;
      forever
      begin
         #2 clk_o = ~clk_o; // half period
      end
   end

endmodule

/* capture_top.sv */
module capture_top import capture_pkg::*;
(
   input  logic                clk_e_i,        // external signal clock
   input  logic                arst_n_i,       // async reset, active low
   input  logic                ce_a_i,         // capture enable, foreign domain
   input  logic                debug_a_i,      // fake data select, foreign domain
   input  logic                store_a_i,      // store request, foreign domain
   input  logic [NUM_ANT-1:0]  antenna_i,      // one-bit antenna samples
   input  logic [STORE_AW-1:0] rd_addr_i,      // raw buffer read address
   output logic [NUM_ANT-1:0]  sample_o,       // captured word
   output logic                sample_valid_o, // captured word strobe
   output logic [NUM_ANT-1:0]  rd_data_o,      // raw buffer read data
   output logic [STORE_AW:0]   store_count_o,  // words stored this session
   output logic                store_full_o    // raw buffer full
);

   logic [NUM_ANT-1:0] fake_bits; // lfsr to frontend

   // synchronised controls
   capture_ctrl_if ctrl_if ();

   //--------------------
   // control domain crossing
   //--------------------
   capture_control u_control
   (
      .clk_e_i   (clk_e_i),
      .arst_n_i  (arst_n_i),
      .ce_a_i    (ce_a_i),
      .debug_a_i (debug_a_i),
      .store_a_i (store_a_i),
      .ctrl      (ctrl_if.ctrl_mp)
   );

   //--------------------
   // sample path
   //--------------------
   fake_antenna_lfsr u_lfsr
   (
      .clk_e_i     (clk_e_i),
      .arst_n_i    (arst_n_i),
      .ctrl        (ctrl_if.user_mp),
      .fake_bits_o (fake_bits)
   );

   sample_frontend u_frontend
   (
      .clk_e_i        (clk_e_i),
      .arst_n_i       (arst_n_i),
      .ctrl           (ctrl_if.user_mp),
      .antenna_i      (antenna_i),
      .fake_bits_i    (fake_bits),
      .sample_o       (sample_o),
      .sample_valid_o (sample_valid_o)
   );

   // raw buffer sees the same words as the outputs
   raw_store u_store
   (
      .clk_e_i        (clk_e_i),
      .arst_n_i       (arst_n_i),
      .ctrl           (ctrl_if.user_mp),
      .sample_i       (sample_o),
      .sample_valid_i (sample_valid_o),
      .rd_addr_i      (rd_addr_i),
      .rd_data_o      (rd_data_o),
      .store_count_o  (store_count_o),
      .store_full_o   (store_full_o)
   );

endmodule

/* raw_store.sv */
module raw_store import capture_pkg::*;
(
   input  logic                clk_e_i,        // external signal clock
   input  logic                arst_n_i,       // async reset, active low
   capture_ctrl_if.user_mp     ctrl,           // synchronised controls
   input  logic [NUM_ANT-1:0]  sample_i,       // captured word
   input  logic                sample_valid_i, // word strobe
   input  logic [STORE_AW-1:0] rd_addr_i,      // read-back address
   output logic [NUM_ANT-1:0]  rd_data_o,      // entry at rd_addr_i, one cycle late
   output logic [STORE_AW:0]   store_count_o,  // words written this session
   output logic                store_full_o    // buffer full
);

   localparam logic [STORE_AW:0] LAST_CNT = (STORE_AW+1)'(STORE_DEPTH - 1);

   store_state_e        state_q;
   logic [STORE_AW:0]   count_q;             // next write address, plus full bit
   logic                wr_en;
   logic [NUM_ANT-1:0]  mem [STORE_DEPTH];   // raw buffer

   // write only while filling and store still requested
   assign wr_en = (state_q == STORE_FILL) & ctrl.store & sample_valid_i;

   //--------------------
   // store FSM
   //--------------------
   always_ff @(posedge clk_e_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q <= STORE_IDLE;
         count_q <= '0;
      end
      else if (ctrl.rst)
      begin
         state_q <= STORE_IDLE;
         count_q <= '0;
      end
      else
      begin
         case (state_q)
            STORE_IDLE:
            begin
               if (ctrl.store)
               begin
                  state_q <= STORE_FILL;
                  count_q <= '0; // new session starts at address 0
               end
            end
            STORE_FILL:
            begin
               if (!ctrl.store)
               begin
                  state_q <= STORE_IDLE; // count and contents kept
               end
               else if (sample_valid_i)
               begin
                  count_q <= count_q + 1'b1;
                  if (count_q == LAST_CNT)
                  begin
                     state_q <= STORE_FULL; // last entry written
                  end
               end
            end
            STORE_FULL:
            begin
               if (!ctrl.store)
               begin
                  state_q <= STORE_IDLE;
               end
               // samples dropped here
            end
            default:
            begin
               state_q <= STORE_IDLE;
            end
         endcase
      end
   end

   //--------------------
   // buffer
   //--------------------
   always_ff @(posedge clk_e_i)
   begin
      if (wr_en)
      begin
         mem[count_q[STORE_AW-1:0]] <= sample_i;
      end
      rd_data_o <= mem[rd_addr_i]; // registered read, separate port
   end

   assign store_count_o = count_q;
   assign store_full_o  = (state_q == STORE_FULL);

endmodule

/* sample_frontend.sv */
module sample_frontend import capture_pkg::*;
(
   input  logic               clk_e_i,        // external signal clock
   input  logic               arst_n_i,       // async reset, active low
   capture_ctrl_if.user_mp    ctrl,           // synchronised controls
   input  logic [NUM_ANT-1:0] antenna_i,      // real one-bit antenna samples
   input  logic [NUM_ANT-1:0] fake_bits_i,    // from the lfsr
   output logic [NUM_ANT-1:0] sample_o,       // captured word
   output logic               sample_valid_o  // one strobe per captured word
);

   logic [NUM_ANT-1:0] sample_sel; // real or fake, before the register

   //--------------------
   // source select
   //--------------------
   assign sample_sel = ctrl.debug ? fake_bits_i : antenna_i;

   //--------------------
   // capture register
   //--------------------
   always_ff @(posedge clk_e_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         sample_o       <= '0;
         sample_valid_o <= 1'b0;
      end
      else if (ctrl.rst)
      begin
         sample_o       <= '0; // cleared on internal reset
         sample_valid_o <= 1'b0;
      end
      else
      begin
         sample_valid_o <= ctrl.ce; // valid for the cycle after capture
         if (ctrl.ce)
         begin
            sample_o <= sample_sel;
         end
         // else hold last word
      end
   end

endmodule

/* fake_antenna_lfsr.sv */
module fake_antenna_lfsr import capture_pkg::*;
(
   input  logic               clk_e_i,     // external signal clock
   input  logic               arst_n_i,    // async reset, active low
   capture_ctrl_if.user_mp    ctrl,        // synchronised controls
   output logic [NUM_ANT-1:0] fake_bits_o  // fake antenna word
);

   logic [LFSR_W-1:0] lfsr_q; // shift register state
   logic              feedback;
   logic              step;   // advance this cycle

   // fibonacci taps 16, 14, 13, 11
   assign feedback = lfsr_q[LFSR_W-1] ^ lfsr_q[LFSR_W-3]
                   ^ lfsr_q[LFSR_W-4] ^ lfsr_q[LFSR_W-6];

   // only runs while fake data is being captured
   assign step = ctrl.ce & ctrl.debug;

   always_ff @(posedge clk_e_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         lfsr_q <= FAKE_SEED;
      end
      else if (ctrl.rst)
      begin
         lfsr_q <= FAKE_SEED; // reload on internal reset
      end
      else if (step)
      begin
         lfsr_q <= {lfsr_q[LFSR_W-2:0], feedback}; // shift left, fb into bit 0
      end
   end

   // Low lanes only, taken before this edge's step
   assign fake_bits_o = lfsr_q[NUM_ANT-1:0];

endmodule

/* capture_control.sv */
module capture_control import capture_pkg::*;
(
   input  logic            clk_e_i,   // external signal clock
   input  logic            arst_n_i,  // async reset, active low
   input  logic            ce_a_i,    // capture enable, foreign bus domain
   input  logic            debug_a_i, // fake data select, foreign domain
   input  logic            store_a_i, // raw store request, foreign domain
   capture_ctrl_if.ctrl_mp ctrl
);

   logic [2:0] lvl_r;                  // re-registered levels {store, debug, ce}
   logic [2:0] lvl_sync [SYNC_STAGES]; // synchroniser chain
   logic [1:0] rst_sync;               // reset synchroniser, bit 1 is the output

   //--------------------
   // input re-register
   //--------------------
   // keeps the foreign levels in one place ahead of the sync chain
   always_ff @(posedge clk_e_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         lvl_r <= '0;
      end
      else
      begin
         lvl_r <= {store_a_i, debug_a_i, ce_a_i};
      end
   end

   //--------------------
   // level synchronisers
   //--------------------
   always_ff @(posedge clk_e_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int i = 0; i < SYNC_STAGES; i++)
         begin
            lvl_sync[i] <= '0; // all levels low
         end
      end
      else
      begin
         lvl_sync[0] <= lvl_r; // first stage may go metastable
         for (int i = 1; i < SYNC_STAGES; i++)
         begin
            lvl_sync[i] <= lvl_sync[i-1];
         end
      end
   end

   // reset asserts at once, releases two edges after arst_n_i rises
   always_ff @(posedge clk_e_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         rst_sync <= 2'b11;
      end
      else
      begin
         rst_sync <= {rst_sync[0], 1'b0}; // shift zeros in
      end
   end

   assign ctrl.rst   = rst_sync[1];
   assign ctrl.ce    = lvl_sync[SYNC_STAGES-1][0];
   assign ctrl.debug = lvl_sync[SYNC_STAGES-1][1];
   assign ctrl.store = lvl_sync[SYNC_STAGES-1][2];

endmodule

/* capture_ctrl_if.sv */
// synchronised control levels, all in the clk_e_i domain
interface capture_ctrl_if;

   logic rst;   // internal reset, released on the clock
   logic ce;    // capture enable
   logic debug; // use fake antenna data
   logic store; // write samples to the raw buffer

   // driven only by capture_control
   modport ctrl_mp
   (
      output rst,
      output ce,
      output debug,
      output store
   );

   // lfsr, frontend and store
   modport user_mp
   (
      input rst,
      input ce,
      input debug,
      input store
   );

endinterface

/* capture_pkg.sv */
package capture_pkg;

   //--------------------
   // antenna and fake data
   //--------------------
   localparam int NUM_ANT = 8;                        // one bit per antenna lane
   localparam int LFSR_W = 16;                        // fake data register width
   localparam logic [LFSR_W-1:0] FAKE_SEED = 16'hACE1; // lfsr start value

   //--------------------
   // raw data buffer
   //--------------------
   localparam int STORE_DEPTH = 64; // words per store session
   localparam int STORE_AW = 6;     // log2 of STORE_DEPTH

   // flops after the input re-register
   localparam int SYNC_STAGES = 2;

   // raw_store FSM
   typedef enum logic [1:0]
   {
      STORE_IDLE = 2'd0, // waiting for store
      STORE_FILL = 2'd1, // writing valid samples
      STORE_FULL = 2'd2  // buffer full, samples dropped
   } store_state_e;

endpackage
